/* design/lightPkg.sv */
package lightPkg;

	// Channel and level sizes
	localparam int ChannelCount = 512;
	localparam int ChanWidth = 9;
	localparam int LevelWidth = 8;
	localparam int CueCount = 5;
	localparam int CueWidth = 3;

	// DMX timing in clock cycles and bit times
	localparam int BitCycles = 4;     // 200 on a 50 MHz board
	localparam int BreakBits = 22;
	localparam int MabBits = 2;
	localparam int StopBits = 2;
	localparam logic [LevelWidth-1:0] StartCode = 8'h00;

	// APB register map
	localparam int ApbAddrWidth = 8;
	localparam logic [ApbAddrWidth-1:0] AddrChannel = 8'h00;
	localparam logic [ApbAddrWidth-1:0] AddrLevel = 8'h04;
	localparam logic [ApbAddrWidth-1:0] AddrCue = 8'h08;
	localparam logic [ApbAddrWidth-1:0] AddrSend = 8'h0C;
	localparam logic [ApbAddrWidth-1:0] AddrStatus = 8'h10;
	localparam int CueRecallBit = 8;  // 1 recall, 0 store

	typedef logic [ChanWidth-1:0] chanT;
	typedef logic [LevelWidth-1:0] levelT;
	typedef logic [CueWidth-1:0] cueT;

endpackage

/* design/levelStore.sv */
`timescale 1ns/1ps

module levelStore import lightPkg::*; (
	input  logic  clk,
	input  logic  rst,
	// Transmitter reads only
	input  logic  txReq,
	input  chanT  txChan,
	output logic  txGnt,
	// Cue engine
	input  logic  cueReq,
	input  logic  cueWrite,
	input  chanT  cueChan,
	input  levelT cueLevel,
	output logic  cueGnt,
	// Console
	input  logic  conReq,
	input  logic  conWrite,
	input  chanT  conChan,
	input  levelT conLevel,
	output logic  conGnt,
	output levelT rdLevel,
	output logic  clearing
);

	levelT levels [ChannelCount];
	chanT  clearIdx;
	chanT  rdChan;

	// Fixed priority and no grant during the sweep
	assign txGnt = !clearing && txReq;
	assign cueGnt = !clearing && cueReq && !txReq;
	assign conGnt = !clearing && conReq && !txReq && !cueReq;

	always_comb
	begin
		if (txGnt)
			rdChan = txChan;
		else if (cueGnt)
			rdChan = cueChan;
		else
			rdChan = conChan;
	end

	// Blackout sweep of one channel per cycle
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			clearing <= 1'b1;
			clearIdx <= '0;
		end
		else if (clearing)
		begin
			clearIdx <= clearIdx + 1'b1;
			if (clearIdx == chanT'(ChannelCount - 1))
				clearing <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (clearing)
			levels[clearIdx] <= '0;
		else if (cueGnt && cueWrite)
			levels[cueChan] <= cueLevel;
		else if (conGnt && conWrite)
			levels[conChan] <= conLevel;
		rdLevel <= levels[rdChan];   // valid the cycle after a grant
	end

	// Masters hold a waiting request until granted
	txHeld: assert property (@(posedge clk) disable iff (!rst)
		txReq && !txGnt |=> txReq && $stable(txChan));
	cueHeld: assert property (@(posedge clk) disable iff (!rst)
		cueReq && !cueGnt |=> cueReq && $stable(cueChan));
	conHeld: assert property (@(posedge clk) disable iff (!rst)
		conReq && !conGnt |=> conReq && $stable(conChan));

endmodule

/* design/cueEngine.sv */
`timescale 1ns/1ps

module cueEngine import lightPkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  logic                cueStart,
	input  logic                cueRecall,
	input  cueT                 cueSel,
	output logic                cueBusy,
	output logic [CueCount-1:0] cueValid,
	// Live-level RAM port
	output logic                memReq,
	output logic                memWrite,
	output chanT                memChan,
	output levelT               memLevel,
	input  logic                memGnt,
	input  levelT               rdLevel
);

	levelT cueMem [CueCount][ChannelCount];

	logic recallMode;
	cueT  sel;
	chanT reqChan;     // next channel to request
	chanT wrChan;      // next channel captured on store
	logic issueDone;
	logic rdPending;   // read data arrives this cycle

	assign memReq = cueBusy && !issueDone;
	assign memWrite = recallMode;
	assign memChan = reqChan;
	assign memLevel = cueMem[sel][reqChan];

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			cueBusy <= 1'b0;
			cueValid <= '0;
			recallMode <= 1'b0;
			sel <= '0;
			reqChan <= '0;
			wrChan <= '0;
			issueDone <= 1'b0;
			rdPending <= 1'b0;
		end
		else if (cueStart)
		begin
			cueBusy <= 1'b1;
			recallMode <= cueRecall;
			sel <= cueSel;
			reqChan <= '0;
			wrChan <= '0;
			issueDone <= 1'b0;
			rdPending <= 1'b0;
		end
		else if (cueBusy)
		begin
			rdPending <= memGnt && !recallMode;
			if (memGnt)
			begin
				reqChan <= reqChan + 1'b1;
				if (reqChan == chanT'(ChannelCount - 1))
				begin
					issueDone <= 1'b1;
					if (recallMode)
						cueBusy <= 1'b0;   // last write just went out
				end
			end
			if (rdPending)
			begin
				wrChan <= wrChan + 1'b1;
				if (wrChan == chanT'(ChannelCount - 1))
				begin
					cueBusy <= 1'b0;
					cueValid[sel] <= 1'b1;
				end
			end
		end
	end

	// Store capture, reads may be several deep
	always_ff @(posedge clk)
	begin
		if (rdPending)
			cueMem[sel][wrChan] <= rdLevel;
	end

	noStartWhileBusy: assert property (@(posedge clk) disable iff (!rst)
		cueStart |-> !cueBusy);

endmodule

/* design/dmxTransmitter.sv */
`timescale 1ns/1ps

module dmxTransmitter import lightPkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  sendStart,
	output logic  txBusy,
	output logic  dmxOut,
	output logic  memReq,
	output chanT  memChan,
	input  logic  memGnt,
	input  levelT rdLevel
);

	typedef enum logic [2:0] {Idle, Break, Mab, StartSlot, ChanSlot} txStateT;

	txStateT state;
	logic [$clog2(BitCycles)-1:0] bitCnt;
	logic [4:0] bitIdx;    // bit time within phase or slot
	chanT  slotChan;       // channel now on the line
	chanT  nextChan;
	logic  rdValid;
	levelT nextLevel;
	levelT shiftReg;
	logic  tick, inSlot, slotEnd, lastSlot;

	assign tick = bitCnt == BitCycles - 1;
	assign inSlot = state == StartSlot || state == ChanSlot;
	assign slotEnd = inSlot && tick && bitIdx == LevelWidth + StopBits;
	assign lastSlot = state == ChanSlot && slotChan == chanT'(ChannelCount - 1);
	assign nextChan = (state == StartSlot) ? '0 : slotChan + 1'b1;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state <= Idle;
			txBusy <= 1'b0;
			bitCnt <= '0;
			bitIdx <= '0;
			slotChan <= '0;
			memReq <= 1'b0;
			memChan <= '0;
			rdValid <= 1'b0;
		end
		else
		begin
			rdValid <= memGnt;
			if (memGnt)
				memReq <= 1'b0;
			if (state == Idle || tick)
				bitCnt <= '0;
			else
				bitCnt <= bitCnt + 1'b1;
			case (state)
				Idle:
					if (sendStart)
					begin
						state <= Break;
						txBusy <= 1'b1;
						bitIdx <= '0;
					end
				Break:
					if (tick)
					begin
						if (bitIdx == BreakBits - 1)
						begin
							state <= Mab;
							bitIdx <= '0;
						end
						else
							bitIdx <= bitIdx + 1'b1;
					end
				Mab:
					if (tick)
					begin
						if (bitIdx == MabBits - 1)
						begin
							state <= StartSlot;
							bitIdx <= '0;
							memReq <= 1'b1;   // channel 0 during start code
							memChan <= '0;
						end
						else
							bitIdx <= bitIdx + 1'b1;
					end
				default:
					if (slotEnd)
					begin
						bitIdx <= '0;
						if (lastSlot)
						begin
							state <= Idle;
							txBusy <= 1'b0;
						end
						else
						begin
							state <= ChanSlot;
							slotChan <= nextChan;
							if (nextChan != chanT'(ChannelCount - 1))
							begin
								memReq <= 1'b1;
								memChan <= nextChan + 1'b1;
							end
						end
					end
					else if (tick)
						bitIdx <= bitIdx + 1'b1;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (rdValid)
			nextLevel <= rdLevel;
		if (state == Mab && tick && bitIdx == MabBits - 1)
			shiftReg <= StartCode;
		else if (slotEnd)
			shiftReg <= nextLevel;
		else if (inSlot && tick && bitIdx != 0 && bitIdx <= LevelWidth)
			shiftReg <= shiftReg >> 1;   // LSB first
	end

	always_comb
	begin
		case (state)
			Break: dmxOut = 1'b0;
			StartSlot, ChanSlot:
				if (bitIdx == 0)
					dmxOut = 1'b0;          // start bit
				else if (bitIdx <= LevelWidth)
					dmxOut = shiftReg[0];
				else
					dmxOut = 1'b1;          // stop bits
			default: dmxOut = 1'b1;
		endcase
	end

	// Next level fetched and latched before the slot boundary
	levelInTime: assert property (@(posedge clk) disable iff (!rst)
		slotEnd |-> !memReq && !rdValid);

endmodule

/* design/consoleRegs.sv */
`timescale 1ns/1ps

module consoleRegs import lightPkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  logic [ApbAddrWidth-1:0] paddr,
	input  logic [31:0]             pwdata,
	output logic [31:0]             prdata,
	output logic                    pready,
	output logic                    pslverr,
	// Level access
	output logic                    conReq,
	output logic                    conWrite,
	output chanT                    conChan,
	output levelT                   conLevel,
	input  logic                    conGnt,
	input  levelT                   rdLevel,
	// Commands
	output logic                    cueStart,
	output logic                    cueRecall,
	output cueT                     cueSel,
	input  logic                    cueBusy,
	input  logic [CueCount-1:0]     cueValid,
	output logic                    sendStart,
	input  logic                    txBusy,
	input  logic                    clearing
);

	chanT chanReg;
	logic granted;    // read data lands this cycle
	logic access;
	logic cueBad;

	assign access = psel && penable;
	assign conWrite = pwrite;
	assign conChan = chanReg;
	assign conLevel = pwdata[LevelWidth-1:0];
	assign cueRecall = pwdata[CueRecallBit];
	assign cueSel = pwdata[CueWidth-1:0];
	assign cueBad = pwdata[CueRecallBit-1:0] >= CueCount;

	always_comb
	begin
		pready = 1'b0;
		pslverr = 1'b0;
		prdata = '0;
		conReq = 1'b0;
		cueStart = 1'b0;
		sendStart = 1'b0;
		if (access)
		begin
			case (paddr)
				AddrChannel:
				begin
					pready = 1'b1;
					prdata = 32'(chanReg);
				end
				AddrLevel:
				begin
					conReq = !granted;
					pready = pwrite ? conGnt : granted;
					prdata = 32'(rdLevel);
				end
				AddrCue:
					if (!pwrite)
						pready = 1'b1;
					else if (!clearing && (cueBad || !cueBusy))
					begin
						pready = 1'b1;
						pslverr = cueBad;
						cueStart = !cueBad;
					end
				AddrSend:
					if (!pwrite)
						pready = 1'b1;
					else if (!clearing && !txBusy)
					begin
						pready = 1'b1;
						sendStart = 1'b1;
					end
				AddrStatus:
				begin
					pready = 1'b1;
					pslverr = pwrite;
					prdata = {21'b0, clearing, txBusy, cueBusy, 3'b0, cueValid};
				end
				default:
				begin
					pready = 1'b1;
					pslverr = 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			chanReg <= '0;
			granted <= 1'b0;
		end
		else
		begin
			granted <= conGnt && !pwrite;
			if (access && pwrite && paddr == AddrChannel)
				chanReg <= pwdata[ChanWidth-1:0];
		end
	end

	// Host keeps a stalled transfer unchanged
	hostHolds: assert property (@(posedge clk) disable iff (!rst)
		access && !pready |=> access && $stable(paddr) && $stable(pwrite) && $stable(pwdata));

endmodule

/* design/lightBoard.sv */
`timescale 1ns/1ps

module lightBoard import lightPkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  logic [ApbAddrWidth-1:0] paddr,
	input  logic [31:0]             pwdata,
	output logic [31:0]             prdata,
	output logic                    pready,
	output logic                    pslverr,
	output logic                    dmxOut
);

	logic txReq, txGnt, cueReq, cueWrite, cueGnt, conReq, conWrite, conGnt;
	chanT txChan, cueChan, conChan;
	levelT cueLevel, conLevel, rdLevel;
	logic clearing, cueStart, cueRecall, cueBusy, sendStart, txBusy;
	cueT cueSel;
	logic [CueCount-1:0] cueValid;

	levelStore store (.clk, .rst, .txReq, .txChan, .txGnt,
		.cueReq, .cueWrite, .cueChan, .cueLevel, .cueGnt,
		.conReq, .conWrite, .conChan, .conLevel, .conGnt,
		.rdLevel, .clearing);

	cueEngine cues (.clk, .rst, .cueStart, .cueRecall, .cueSel, .cueBusy, .cueValid,
		.memReq(cueReq), .memWrite(cueWrite), .memChan(cueChan), .memLevel(cueLevel),
		.memGnt(cueGnt), .rdLevel);

	dmxTransmitter tx (.clk, .rst, .sendStart, .txBusy, .dmxOut,
		.memReq(txReq), .memChan(txChan), .memGnt(txGnt), .rdLevel);

	consoleRegs regs (.clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr,
		.conReq, .conWrite, .conChan, .conLevel, .conGnt, .rdLevel,
		.cueStart, .cueRecall, .cueSel, .cueBusy, .cueValid,
		.sendStart, .txBusy, .clearing);

endmodule

/* verif/lightBoardTb.sv */
`timescale 1ns/1ps

module lightBoardTb import lightPkg::*; ();

	localparam int ApbTimeout = 30000;    // longer than one frame
	localparam int FrameTimeout = 30000;
	localparam int LineLimit = 1000;

	logic clk, rst, psel, penable, pwrite;
	logic [ApbAddrWidth-1:0] paddr;
	logic [31:0] pwdata, prdata;
	logic pready, pslverr, dmxOut;

	levelT model [ChannelCount];
	levelT cueModel [CueCount][ChannelCount];
	logic [CueCount-1:0] validModel;
	logic [31:0] lfsrState;
	levelT gotQ [$];
	levelT expQ [$];
	string whatQ [$];
	int errors, checks, tests, framesSeen, frameTarget;
	logic checkFrame;

	lightBoard UUT (.clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .dmxOut);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] takeBits(input int count);
		logic [31:0] value;
		int i;
		value = '0;
		for (i = 0; i < count; i++)
		begin
			lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'h8020_0003 : lfsrState >> 1;
			value = {value[30:0], lfsrState[0]};
		end
		return value;
	endfunction

	function automatic levelT refLevel(input int ch);
		return model[ch];
	endfunction

	task automatic queueCheck(input levelT got, input levelT want, input string what);
		gotQ.push_back(got);
		expQ.push_back(want);
		whatQ.push_back(what);
	endtask

	task automatic apbAccess(input logic wr, input logic [ApbAddrWidth-1:0] addr,
		input logic [31:0] data, output logic [31:0] rdata, output logic err, output int waited);
		logic seen;
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		waited = 0;
		seen = 1'b0;
		while (!seen && waited < ApbTimeout)
		begin
			@(negedge clk);
			if (pready)
				seen = 1'b1;
			else
				waited++;
		end
		rdata = prdata;
		err = pslverr;
		if (!seen)
		begin
			errors++;
			$display("%0t: APB access to address %02h timed out", $time, addr);
		end
		@(posedge clk);   // completing edge
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic setLevel(input chanT ch, input levelT lvl);
		logic [31:0] rd;
		logic err;
		int waited;
		apbAccess(1'b1, AddrChannel, 32'(ch), rd, err, waited);
		apbAccess(1'b1, AddrLevel, 32'(lvl), rd, err, waited);
		model[ch] = lvl;
	endtask

	task automatic readLevel(input chanT ch);
		logic [31:0] rd;
		logic err;
		int waited;
		apbAccess(1'b1, AddrChannel, 32'(ch), rd, err, waited);
		apbAccess(1'b0, AddrLevel, 32'd0, rd, err, waited);
		queueCheck(rd[LevelWidth-1:0], refLevel(ch), $sformatf("read-back of channel %0d", ch));
	endtask

	task automatic checkMask();
		logic [31:0] rd;
		logic err;
		int waited;
		apbAccess(1'b0, AddrStatus, 32'd0, rd, err, waited);
		queueCheck(levelT'(rd[CueCount-1:0]), levelT'(validModel), "cue valid mask");
	endtask

	task automatic waitStatusClear(input int bitPos);
		logic [31:0] rd;
		logic err;
		int waited, tries;
		rd = '1;
		tries = 0;
		while (rd[bitPos] && tries < 1000)
		begin
			apbAccess(1'b0, AddrStatus, 32'd0, rd, err, waited);
			tries++;
		end
		if (rd[bitPos])
		begin
			errors++;
			$display("%0t: STATUS bit %0d never cleared", $time, bitPos);
		end
	endtask

	task automatic storeModel(input int cue);
		int c;
		for (c = 0; c < ChannelCount; c++)
			cueModel[cue][c] = model[c];
		validModel[cue] = 1'b1;
	endtask

	task automatic recallModel(input int cue);
		int c;
		for (c = 0; c < ChannelCount; c++)
			model[c] = cueModel[cue][c];
	endtask

	task automatic sendFrame(input logic check, output int waited);
		logic [31:0] rd;
		logic err;
		checkFrame = check;
		apbAccess(1'b1, AddrSend, 32'd0, rd, err, waited);
		frameTarget = framesSeen + 1;   // any earlier frame has ended by now
	endtask

	task automatic waitFrame();
		int waited;
		waited = 0;
		while (framesSeen < frameTarget && waited < FrameTimeout)
		begin
			@(negedge clk);
			waited++;
		end
		if (framesSeen < frameTarget)
		begin
			errors++;
			$display("%0t: no complete DMX frame arrived in time", $time);
		end
	endtask

	task automatic finishTest(input string name, input int errBefore);
		int waited;
		waited = 0;
		while (gotQ.size() > 0 && waited < 100)
		begin
			@(posedge clk);
			waited++;
		end
		if (gotQ.size() > 0)
		begin
			errors++;
			$display("%0t: pending checks were never compared", $time);
		end
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - errBefore);
	endtask

	// Called at the first sample of slot's start bit, bit centres every BitCycles
	task automatic decodeSlot(input int slot, output levelT value);
		int b;
		value = '0;
		repeat (BitCycles / 2) @(negedge clk);
		if (dmxOut != 1'b0)
		begin
			errors++;
			$display("%0t: start bit of slot %0d is not low", $time, slot);
		end
		for (b = 0; b < LevelWidth; b++)
		begin
			repeat (BitCycles) @(negedge clk);
			value[b] = dmxOut;   // LSB first
		end
		for (b = 0; b < StopBits; b++)
		begin
			repeat (BitCycles) @(negedge clk);
			if (dmxOut != 1'b1)
			begin
				errors++;
				$display("%0t: stop bit %0d of slot %0d is not high", $time, b, slot);
			end
		end
	endtask

	task automatic decodeFrame();
		int lowCnt, highCnt, gap, slot;
		logic check;
		levelT value;
		check = checkFrame;
		lowCnt = 0;
		highCnt = 0;
		while (dmxOut == 1'b0 && lowCnt < LineLimit)
		begin
			lowCnt++;
			@(negedge clk);
		end
		while (dmxOut == 1'b1 && highCnt < LineLimit)
		begin
			highCnt++;
			@(negedge clk);
		end
		if (lowCnt >= LineLimit || highCnt >= LineLimit)
		begin
			errors++;
			$display("%0t: DMX line stuck after break, frame dropped", $time);
			return;
		end
		if (lowCnt < BreakBits * BitCycles)
		begin
			errors++;
			$display("%0t: break lasted only %0d cycles", $time, lowCnt);
		end
		if (highCnt != MabBits * BitCycles)
		begin
			errors++;
			$display("%0t: mark-after-break lasted %0d cycles", $time, highCnt);
		end
		for (slot = 0; slot <= ChannelCount; slot++)
		begin
			decodeSlot(slot, value);
			if (slot == 0)
				queueCheck(value, StartCode, "start code");
			else if (check)
				queueCheck(value, refLevel(slot - 1),
					$sformatf("frame slot of channel %0d", slot - 1));
			gap = 0;
			while (slot < ChannelCount && dmxOut == 1'b1 && gap < 4 * BitCycles)
			begin
				gap++;
				@(negedge clk);
			end
			if (gap >= 4 * BitCycles)
			begin
				errors++;
				$display("%0t: no start bit followed slot %0d", $time, slot);
				return;
			end
		end
		framesSeen++;
	endtask

	// DMX line monitor
	initial
	begin
		forever
		begin
			@(negedge clk);
			if (rst && dmxOut == 1'b0)
				decodeFrame();
		end
	end

	// Compares queued results against the model's expectations
	initial
	begin
		levelT got, want;
		string what;
		forever
		begin
			@(posedge clk);
			while (gotQ.size() > 0)
			begin
				got = gotQ.pop_front();
				want = expQ.pop_front();
				what = whatQ.pop_front();
				checks++;
				if (got != want)
				begin
					errors++;
					$display("mismatch at %0t: %s is %02h, expected %02h", $time, what, got, want);
				end
			end
		end
	end

	initial
	begin
		logic [31:0] rd;
		logic err;
		int waited, errBefore, i, c;
		chanT picked [16];
		rst = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		lfsrState = 32'h2b65;
		errors = 0;
		checks = 0;
		tests = 0;
		framesSeen = 0;
		frameTarget = 0;
		checkFrame = 1'b0;
		validModel = '0;
		for (c = 0; c < ChannelCount; c++)
			model[c] = '0;   // blackout
		repeat (16) @(posedge clk);
		rst <= 1'b1;

		errBefore = errors;
		waitStatusClear(10);
		sendFrame(1'b1, waited);
		waitFrame();
		finishTest("blackout frame", errBefore);

		errBefore = errors;
		for (i = 0; i < 16; i++)
		begin
			picked[i] = chanT'(takeBits(ChanWidth));
			setLevel(picked[i], levelT'(takeBits(LevelWidth)));
		end
		for (i = 0; i < 16; i++)
			readLevel(picked[i]);
		sendFrame(1'b1, waited);
		waitFrame();
		finishTest("random levels", errBefore);

		errBefore = errors;
		apbAccess(1'b1, AddrCue, 32'd2, rd, err, waited);
		storeModel(2);
		waitStatusClear(8);
		for (i = 0; i < 16; i++)
		begin
			picked[i] = chanT'(takeBits(ChanWidth));
			setLevel(picked[i], levelT'(takeBits(LevelWidth)));
		end
		apbAccess(1'b1, AddrCue, 32'h102, rd, err, waited);   // recall cue 2
		recallModel(2);
		waitStatusClear(8);
		for (i = 0; i < 16; i++)
			readLevel(picked[i]);
		checkMask();
		sendFrame(1'b1, waited);
		waitFrame();
		finishTest("cue store and recall", errBefore);

		errBefore = errors;
		apbAccess(1'b1, AddrCue, 32'd5, rd, err, waited);
		queueCheck(levelT'(err), 8'd1, "slave error for cue 5");
		apbAccess(1'b1, AddrCue, 32'h107, rd, err, waited);
		queueCheck(levelT'(err), 8'd1, "slave error for recall of cue 7");
		apbAccess(1'b1, 8'h14, 32'h55, rd, err, waited);
		queueCheck(levelT'(err), 8'd1, "slave error for write to address 14");
		apbAccess(1'b0, 8'h40, 32'd0, rd, err, waited);
		queueCheck(levelT'(err), 8'd1, "slave error for read of address 40");
		apbAccess(1'b1, AddrStatus, 32'hFFFF_FFFF, rd, err, waited);
		queueCheck(levelT'(err), 8'd1, "slave error for write to STATUS");
		checkMask();
		for (i = 0; i < 16; i++)
			readLevel(picked[i]);
		finishTest("bad accesses", errBefore);

		errBefore = errors;
		sendFrame(1'b0, waited);   // framing only, levels change under it
		for (i = 0; i < 8; i++)
			setLevel(chanT'(takeBits(ChanWidth)), levelT'(takeBits(LevelWidth)));
		apbAccess(1'b1, AddrCue, 32'd4, rd, err, waited);
		storeModel(4);
		apbAccess(1'b1, AddrCue, 32'd3, rd, err, waited);
		storeModel(3);
		if (waited == 0)
		begin
			errors++;
			$display("%0t: second CUE store did not wait for the busy cue engine", $time);
		end
		sendFrame(1'b1, waited);
		if (waited == 0)
		begin
			errors++;
			$display("%0t: SEND did not wait for the busy transmitter", $time);
		end
		waitFrame();
		waitStatusClear(8);
		checkMask();
		finishTest("traffic during a frame", errBefore);

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* lightBoard.f */
design/lightPkg.sv
design/levelStore.sv
design/cueEngine.sv
design/dmxTransmitter.sv
design/consoleRegs.sv
design/lightBoard.sv
verif/lightBoardTb.sv

/* runSim.sh */
#!/bin/sh
# Build and run the lightBoard testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module lightBoardTb \
	-f lightBoard.f -o lightBoardSim || exit 1
simOut="$(./obj_dir/lightBoardSim)"
echo "$simOut"
echo "$simOut" | grep -q "Simulation finished: PASS" && echo "run passed" || {
	echo "run failed"
	exit 1
}
